//--- ascon_hash_top.f
+incdir+testbench
hdl/ascon_pkg.sv
hdl/hash_pkg.sv
hdl/block_if.sv
hdl/perm_if.sv
hdl/ascon_round.sv
hdl/ascon_permutation.sv
hdl/ascon_padder.sv
hdl/hash_ctrl.sv
hdl/ascon_hash_top.sv
testbench/tb_clock_gen.sv
testbench/tb_ascon_hash_top.sv

//--- testbench/tb_ascon_ref.svh
// ----------------------------------------------------------
// Software model of Ascon-Hash256 for the testbench
// Permutation, padding, digest and the stimulus LFSR
// ----------------------------------------------------------
`ifndef TB_ASCON_REF_SVH
`define TB_ASCON_REF_SVH

// Longest message the tests send, in bytes
localparam int MAX_BYTES = 48;

// Ascon 5-bit S-box, entry i in bits 5i+4:5i
// Input and output columns carry x0 in their top bit
localparam logic [159:0] SBOX_TABLE = {
    5'h17, 5'h0f, 5'h0a, 5'h16, 5'h19, 5'h01, 5'h0c, 5'h10,
    5'h18, 5'h11, 5'h0d, 5'h00, 5'h0e, 5'h07, 5'h13, 5'h1e,
    5'h1c, 5'h06, 5'h03, 5'h1d, 5'h12, 5'h08, 5'h05, 5'h1b,
    5'h02, 5'h09, 5'h15, 5'h1a, 5'h14, 5'h1f, 5'h0b, 5'h04
};

// Rotate a lane right through a doubled copy
function automatic logic [63:0] rotr64(input logic [63:0] v, input int n);
    logic [127:0] w;
    w = {v, v} >> n;
    return w[63:0];
endfunction

// Full p12, lane i of the state in bits 64i+63:64i
function automatic logic [319:0] p12_ref(input logic [319:0] s_in);
    logic [4:0][63:0] x;
    logic [4:0][63:0] y;
    logic [4:0]       col;
    logic [4:0]       sub;
    logic [7:0]       rc;
    x = s_in;
    for (int r = 0; r < 12; r++) begin
        // High nibble counts down while low nibble counts up
        rc = 8'((15 - r) * 16 + r);
        x[2][7:0] = x[2][7:0] ^ rc;
        // S-box applied column by column
        for (int j = 0; j < 64; j++) begin
            col = {x[0][j], x[1][j], x[2][j], x[3][j], x[4][j]};
            sub = SBOX_TABLE[5*col +: 5];
            for (int i = 0; i < 5; i++) begin
                y[i][j] = sub[4-i];
            end
        end
        x[0] = y[0] ^ rotr64(y[0], 19) ^ rotr64(y[0], 28);
        x[1] = y[1] ^ rotr64(y[1], 61) ^ rotr64(y[1], 39);
        x[2] = y[2] ^ rotr64(y[2], 1) ^ rotr64(y[2], 6);
        x[3] = y[3] ^ rotr64(y[3], 10) ^ rotr64(y[3], 17);
        x[4] = y[4] ^ rotr64(y[4], 7) ^ rotr64(y[4], 41);
    end
    return x;
endfunction

// Block k of the padded message, 0x01 right after the last byte
function automatic logic [63:0] pad_block(input logic [8*MAX_BYTES-1:0] msg,
                                          input int len, input int k);
    logic [63:0] blk;
    int          pos;
    blk = '0;
    for (int b = 0; b < 8; b++) begin
        pos = 8 * k + b;
        if (pos < len) begin
            blk[8*b +: 8] = msg[8*pos +: 8];
        end else if (pos == len) begin
            blk[8*b +: 8] = 8'h01;
        end
    end
    return blk;
endfunction

// Digest as four words, word 0 in bits 63:0
function automatic logic [255:0] hash256_ref(input logic [8*MAX_BYTES-1:0] msg,
                                             input int len);
    logic [319:0] s;
    logic [255:0] dig;
    s = {256'd0, 64'h0000080100cc0002};
    s = p12_ref(s);
    // Always len/8 + 1 blocks once padded
    for (int k = 0; k <= len / 8; k++) begin
        s[63:0] = s[63:0] ^ pad_block(msg, len, k);
        s = p12_ref(s);
    end
    for (int w = 0; w < 4; w++) begin
        dig[64*w +: 64] = s[63:0];
        if (w < 3) begin
            s = p12_ref(s);
        end
    end
    return dig;
endfunction

// One step of a 32-bit Galois LFSR
function automatic logic [31:0] lfsr_next(input logic [31:0] v);
    return v[0] ? ((v >> 1) ^ 32'h80200003) : (v >> 1);
endfunction

`endif

//--- testbench/tb_ascon_hash_top.sv
// ----------------------------------------------------------
// Testbench for the Ascon-Hash256 accelerator
// Streams messages in and checks each digest beat on a model
// ----------------------------------------------------------
`timescale 1ns/10ps

module tb_ascon_hash_top;

    `include "tb_ascon_ref.svh"

    localparam int NUM_TESTS   = 20;
    localparam int DRIVE_DELAY = 10;

    logic        clk;
    logic        rst_i;
    logic        start_i;
    logic        busy_o;
    logic        done_o;
    logic [63:0] s_tdata_i;
    logic [7:0]  s_tkeep_i;
    logic        s_tlast_i;
    logic        s_tvalid_i;
    logic        s_tready_o;
    logic [63:0] m_tdata_o;
    logic        m_tlast_o;
    logic        m_tvalid_o;
    logic        m_tready_i;

    // Stimulus state
    logic [31:0]            lfsr_q;
    logic [8*MAX_BYTES-1:0] msg_vec;
    int                     test_len [NUM_TESTS];
    bit                     test_stress [NUM_TESTS];
    bit                     stress_mode = 1'b0;
    logic                   ready_next = 1'b1;

    // Scoreboard state
    logic [63:0] exp_q [$];
    int          beat_idx    = 0;
    int          ops_done    = 0;
    int          done_cnt    = 0;
    int          err_cnt     = 0;
    int          pass_cnt    = 0;
    int          fail_cnt    = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;

    tb_clock_gen #(.PERIOD_NS(100)) u_clock_gen (.clk_o(clk));

    ascon_hash_top #(
        .ROUNDS_PER_CYCLE (1)
    ) u_ascon_hash_top (
        .clk        (clk),
        .rst_i      (rst_i),
        .start_i    (start_i),
        .busy_o     (busy_o),
        .done_o     (done_o),
        .s_tdata_i  (s_tdata_i),
        .s_tkeep_i  (s_tkeep_i),
        .s_tlast_i  (s_tlast_i),
        .s_tvalid_i (s_tvalid_i),
        .s_tready_o (s_tready_o),
        .m_tdata_o  (m_tdata_o),
        .m_tlast_o  (m_tlast_o),
        .m_tvalid_o (m_tvalid_o),
        .m_tready_i (m_tready_i)
    );

    // Pulls n bits from the LFSR with one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r      = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return r;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic wait_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // ------------------------------------------------------
    // Output monitor sampled mid-cycle where all is settled
    // ------------------------------------------------------
    always @(negedge clk) begin
        // Every done pulse is counted on its own
        if (!rst_i && done_o) begin
            done_cnt++;
        end
        if (!rst_i && m_tvalid_o && m_tready_i) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t ns: digest beat arrived with nothing expected", $time);
                err_cnt++;
            end else begin
                check_value("digest word", m_tdata_o, exp_q.pop_front());
            end
            check_value("m_tlast_o", 64'(m_tlast_o), 64'(beat_idx == 3));
            check_value("done_o", 64'(done_o), 64'(beat_idx == 3));
            if (beat_idx == 3) begin
                beat_idx = 0;
                ops_done++;
            end else begin
                beat_idx++;
            end
        end else if (!rst_i && done_o) begin
            $display("Error at %0t ns: done_o pulsed without a final digest handshake", $time);
            err_cnt++;
        end
    end

    // Back-pressure drawn mid-cycle and applied after the edge
    always @(negedge clk) begin
        if (stress_mode) begin
            ready_next = take_bits(1) != 0;
        end else begin
            ready_next = 1'b1;
        end
    end

    always @(posedge clk) begin
        #DRIVE_DELAY;
        m_tready_i = ready_next;
    end

    // Hang guard
    initial begin
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles: the DUT hangs and never finished", cycle_cnt);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // Idle outputs before any start
    task automatic check_idle();
        @(negedge clk);
        check_value("busy_o", 64'(busy_o), 64'd0);
        check_value("done_o", 64'(done_o), 64'd0);
        check_value("m_tvalid_o", 64'(m_tvalid_o), 64'd0);
        check_value("s_tready_o", 64'(s_tready_o), 64'd0);
        wait_cycle();
    endtask

    // Streams msg_vec as beats with optional random gaps before each
    task automatic send_message(input int len);
        int nbeats;
        int nbytes;
        int gap;
        bit accepted;
        nbeats = (len == 0) ? 1 : (len + 7) / 8;
        for (int k = 0; k < nbeats; k++) begin
            if (stress_mode) begin
                gap = int'(take_bits(2));
                repeat (gap) wait_cycle();
            end
            nbytes     = (len - 8 * k > 8) ? 8 : len - 8 * k;
            s_tdata_i  = msg_vec[64*k +: 64];
            s_tkeep_i  = 8'((16'd1 << nbytes) - 16'd1);
            s_tlast_i  = (k == nbeats - 1);
            s_tvalid_i = 1'b1;
            accepted   = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = s_tready_o;
                wait_cycle();
            end
            s_tvalid_i = 1'b0;
            s_tlast_i  = 1'b0;
        end
    endtask

    // One full hash operation with its check and report line
    task automatic run_test(input int idx);
        int           len;
        int           errs_before;
        int           ops_before;
        int           done_before;
        logic [255:0] digest;
        len         = test_len[idx];
        stress_mode = test_stress[idx];
        errs_before = err_cnt;
        ops_before  = ops_done;
        done_before = done_cnt;
        // Bytes past the end land in disabled lanes as junk
        for (int i = 0; i < MAX_BYTES; i++) begin
            msg_vec[8*i +: 8] = 8'(take_bits(8));
        end
        digest = hash256_ref(msg_vec, len);
        for (int w = 0; w < 4; w++) begin
            exp_q.push_back(digest[64*w +: 64]);
        end
        start_i = 1'b1;
        @(negedge clk);
        check_value("busy_o before start", 64'(busy_o), 64'd0);
        wait_cycle();
        start_i = 1'b0;
        @(negedge clk);
        check_value("busy_o after start", 64'(busy_o), 64'd1);
        wait_cycle();
        send_message(len);
        while (ops_done == ops_before) begin
            wait_cycle();
        end
        // Back to idle with exactly one done pulse
        repeat (2) wait_cycle();
        @(negedge clk);
        check_value("busy_o after done", 64'(busy_o), 64'd0);
        check_value("done pulses", 64'(done_cnt - done_before), 64'd1);
        check_value("pending digest words", 64'(exp_q.size()), 64'd0);
        wait_cycle();
        if (err_cnt == errs_before) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("Test %0d (%0d bytes, %s): %s", idx, len,
                 stress_mode ? "stressed" : "steady",
                 (err_cnt == errs_before) ? "passed" : "failed");
    endtask

    // ------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------
    initial begin
        int total_blocks;
        int idle_errs;
        rst_i      = 1'b1;
        start_i    = 1'b0;
        s_tdata_i  = '0;
        s_tkeep_i  = '0;
        s_tlast_i  = 1'b0;
        s_tvalid_i = 1'b0;
        m_tready_i = 1'b1;
        lfsr_q     = 32'h4ddc;

        // Empty, in-beat padding, multi-beat, whole blocks, then random
        test_len[0] = 0;
        for (int i = 1; i <= 7; i++) begin
            test_len[i] = i;
        end
        test_len[8]  = 11;
        test_len[9]  = 18;
        test_len[10] = 29;
        test_len[11] = 8;
        test_len[12] = 16;
        test_len[13] = 40;
        for (int i = 0; i < NUM_TESTS; i++) begin
            test_stress[i] = (i >= 14);
            if (i >= 14) begin
                test_len[i] = int'(take_bits(6)) % (MAX_BYTES + 1);
            end
        end

        // Each block costs p12 plus a beat and each test adds init and four squeezes
        total_blocks = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            total_blocks += test_len[i] / 8 + 1;
        end
        cycle_limit = 2 * (total_blocks * (12 + 4) +
                           NUM_TESTS * (12 + 4 * (12 + 4) + 8)) + 200;

        repeat (4) wait_cycle();
        rst_i = 1'b0;

        idle_errs = err_cnt;
        repeat (3) check_idle();
        if (err_cnt == idle_errs) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("Reset idle check: %s", (err_cnt == idle_errs) ? "passed" : "failed");

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock_gen.sv
// ----------------------------------------------------------
// Free-running testbench clock
// ----------------------------------------------------------
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    // Starts low, first rising edge at half a period
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

//--- hdl/ascon_hash_top.sv
// ----------------------------------------------------------
// Ascon-Hash256 accelerator top level
// Ties padder, permutation and controller to stream ports
// ----------------------------------------------------------
`timescale 1ns/10ps

module ascon_hash_top #(
    parameter int ROUNDS_PER_CYCLE = 1
) (
    input  logic              clk,
    input  logic              rst_i,

    // Operation control
    input  logic              start_i,
    output logic              busy_o,
    output logic              done_o,

    // Message stream in
    input  hash_pkg::block_t  s_tdata_i,
    input  hash_pkg::keep_t   s_tkeep_i,
    input  logic              s_tlast_i,
    input  logic              s_tvalid_i,
    output logic              s_tready_o,

    // Digest stream out
    output hash_pkg::block_t  m_tdata_o,
    output logic              m_tlast_o,
    output logic              m_tvalid_o,
    input  logic              m_tready_i
);

    // ------------------------------------------------------
    // Internal channels
    // ------------------------------------------------------
    block_if u_blk_if ();
    perm_if  u_perm_if ();

    // Framer, only takes beats while an operation is running
    ascon_padder u_padder (
        .clk        (clk),
        .rst_i      (rst_i),
        .active_i   (busy_o),
        .s_tdata_i  (s_tdata_i),
        .s_tkeep_i  (s_tkeep_i),
        .s_tlast_i  (s_tlast_i),
        .s_tvalid_i (s_tvalid_i),
        .s_tready_o (s_tready_o),
        .blk        (u_blk_if.padder)
    );

    // Protocol-agnostic p12 core
    ascon_permutation #(
        .ROUNDS_PER_CYCLE (ROUNDS_PER_CYCLE)
    ) u_permutation (
        .clk   (clk),
        .rst_i (rst_i),
        .perm  (u_perm_if.perm)
    );

    // Sponge scheduling and digest output
    hash_ctrl u_hash_ctrl (
        .clk        (clk),
        .rst_i      (rst_i),
        .start_i    (start_i),
        .busy_o     (busy_o),
        .done_o     (done_o),
        .blk        (u_blk_if.ctrl),
        .perm       (u_perm_if.ctrl),
        .m_tdata_o  (m_tdata_o),
        .m_tlast_o  (m_tlast_o),
        .m_tvalid_o (m_tvalid_o),
        .m_tready_i (m_tready_i)
    );

endmodule

//--- hdl/hash_ctrl.sv
// ----------------------------------------------------------
// Ascon-Hash256 sponge controller
// Init, absorb, final permutation and four-beat squeeze
// ----------------------------------------------------------
`timescale 1ns/10ps

module hash_ctrl (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              start_i,
    output logic              busy_o,
    output logic              done_o,
    block_if.ctrl             blk,
    perm_if.ctrl              perm,
    output hash_pkg::block_t  m_tdata_o,
    output logic              m_tlast_o,
    output logic              m_tvalid_o,
    input  logic              m_tready_i
);

    // FSM encoding
    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_INIT    = 3'd1;
    localparam logic [2:0] ST_ABSORB  = 3'd2;
    localparam logic [2:0] ST_SQUEEZE = 3'd3;
    localparam logic [2:0] ST_WAIT    = 3'd4;

    logic [2:0]          state_q, state_d;
    logic                to_squeeze_q, to_squeeze_d;
    hash_pkg::beat_cnt_t beat_cnt_q;
    ascon_pkg::state_u   cur;
    ascon_pkg::state_u   nxt;
    logic                blk_xfer;
    logic                out_xfer;
    logic                last_beat;

    // Lane view of the permutation register
    always_comb begin
        cur.flat = perm.state;
    end

    // ------------------------------------------------------
    // Handshakes and status
    // ------------------------------------------------------
    assign busy_o        = (state_q != ST_IDLE);
    assign blk.blk_ready = (state_q == ST_ABSORB) && perm.ready;
    assign blk_xfer      = blk.blk_valid && blk.blk_ready;
    assign last_beat     = (beat_cnt_q == hash_pkg::beat_cnt_t'(hash_pkg::DIGEST_WORDS - 1));

    // Digest beat is x0, stable since the core is idle while squeezing
    assign m_tvalid_o = (state_q == ST_SQUEEZE);
    assign m_tdata_o  = cur.x[0];
    assign m_tlast_o  = m_tvalid_o && last_beat;
    assign out_xfer   = m_tvalid_o && m_tready_i;
    assign done_o     = out_xfer && last_beat;

    // Next state for the core, either the IV or x0 XOR block
    always_comb begin
        nxt = '0;
        if (state_q == ST_INIT) begin
            nxt.x[0] = hash_pkg::HASH_IV;
        end else begin
            nxt      = cur;
            nxt.x[0] = cur.x[0] ^ blk.blk_data;
        end
    end

    assign perm.load_state = nxt.flat;
    assign perm.load       = ((state_q == ST_INIT) && perm.ready) || blk_xfer;
    // Every load runs p12, and so does each squeeze beat but the last
    assign perm.start      = perm.load || (out_xfer && !last_beat);

    // ------------------------------------------------------
    // Next-state logic
    // ------------------------------------------------------
    always_comb begin
        state_d      = state_q;
        to_squeeze_d = to_squeeze_q;
        case (state_q)
            ST_IDLE: begin
                if (start_i) state_d = ST_INIT;
            end
            ST_INIT: begin
                if (perm.ready) begin
                    state_d      = ST_WAIT;
                    to_squeeze_d = 1'b0;
                end
            end
            ST_ABSORB: begin
                // Final block sends us to squeeze after its p12
                if (blk_xfer) begin
                    state_d      = ST_WAIT;
                    to_squeeze_d = blk.blk_final;
                end
            end
            ST_WAIT: begin
                if (perm.ready) state_d = to_squeeze_q ? ST_SQUEEZE : ST_ABSORB;
            end
            ST_SQUEEZE: begin
                if (out_xfer) state_d = last_beat ? ST_IDLE : ST_WAIT;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q      <= ST_IDLE;
            to_squeeze_q <= 1'b0;
            beat_cnt_q   <= '0;
        end else begin
            state_q      <= state_d;
            to_squeeze_q <= to_squeeze_d;
            // Beat counter wraps back to zero after the fourth beat
            if (state_q == ST_INIT) begin
                beat_cnt_q <= '0;
            end else if (out_xfer) begin
                beat_cnt_q <= beat_cnt_q + 2'd1;
            end
        end
    end

endmodule

//--- hdl/ascon_padder.sv
// ----------------------------------------------------------
// Stream framer for the hash sponge
// Pads byte-enabled beats into 64-bit blocks, marks the last
// ----------------------------------------------------------
`timescale 1ns/10ps

module ascon_padder (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              active_i,
    input  hash_pkg::block_t  s_tdata_i,
    input  hash_pkg::keep_t   s_tkeep_i,
    input  logic              s_tlast_i,
    input  logic              s_tvalid_i,
    output logic              s_tready_o,
    block_if.padder           blk
);

    hash_pkg::block_t hold_data;
    hash_pkg::block_t pad_data;
    hash_pkg::keep_t  pad_pos;
    logic             hold_valid;
    logic             hold_final;
    logic             pend_extra;
    logic             full_beat;
    logic             beat_xfer;
    logic             blk_xfer;

    // Single-entry holder, so input stalls while a block waits
    assign s_tready_o = active_i && !hold_valid;
    assign beat_xfer  = s_tvalid_i && s_tready_o;
    assign blk_xfer   = blk.blk_valid && blk.blk_ready;
    assign full_beat  = &s_tkeep_i;

    // One-hot position of the first disabled byte
    assign pad_pos = ~s_tkeep_i & {s_tkeep_i[hash_pkg::KEEP_BITS-2:0], 1'b1};

    // Keep enabled bytes, drop in 0x01 right after them, zero the rest
    always_comb begin
        for (int b = 0; b < hash_pkg::KEEP_BITS; b++) begin
            if (s_tkeep_i[b]) begin
                pad_data[8*b +: 8] = s_tdata_i[8*b +: 8];
            end else begin
                pad_data[8*b +: 8] = pad_pos[b] ? 8'h01 : 8'h00;
            end
        end
    end

    // ------------------------------------------------------
    // Holder control
    // ------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            hold_valid <= 1'b0;
            hold_final <= 1'b0;
            pend_extra <= 1'b0;
        end else if (blk_xfer) begin
            // Full last beat owes one more block holding only the pad byte
            if (pend_extra) begin
                hold_final <= 1'b1;
                pend_extra <= 1'b0;
            end else begin
                hold_valid <= 1'b0;
            end
        end else if (beat_xfer) begin
            hold_valid <= 1'b1;
            hold_final <= s_tlast_i && !full_beat;
            pend_extra <= s_tlast_i && full_beat;
        end
    end

    // Block payload
    always_ff @(posedge clk) begin
        if (blk_xfer && pend_extra) begin
            hold_data <= hash_pkg::block_t'(1);
        end else if (beat_xfer) begin
            hold_data <= pad_data;
        end
    end

    assign blk.blk_data  = hold_data;
    assign blk.blk_final = hold_final;
    assign blk.blk_valid = hold_valid;

endmodule

//--- hdl/ascon_permutation.sv
// ----------------------------------------------------------
// Ascon p12 core with its state register
// Runs ROUNDS_PER_CYCLE unrolled rounds on every clock
// ----------------------------------------------------------
`timescale 1ns/10ps

module ascon_permutation #(
    parameter int ROUNDS_PER_CYCLE = 1
) (
    input  logic  clk,
    input  logic  rst_i,
    perm_if.perm  perm
);

    ascon_pkg::state_u     state_q;
    ascon_pkg::state_u     chain [ROUNDS_PER_CYCLE+1];
    ascon_pkg::round_idx_t round_cnt;
    ascon_pkg::round_idx_t round_base;
    logic                  running;
    logic                  last_step;

    // First step runs on the start cycle itself, from round 0
    assign round_base = running ? round_cnt : '0;
    assign last_step  = running &&
                        (int'(round_cnt) + ROUNDS_PER_CYCLE >= ascon_pkg::ROUNDS);

    // A load in the same cycle as start feeds the rounds directly
    always_comb begin
        chain[0].flat = perm.load ? perm.load_state : state_q.flat;
    end

    // Unrolled round chain
    for (genvar k = 0; k < ROUNDS_PER_CYCLE; k++) begin : g_round
        ascon_round u_round (
            .state_i (chain[k]),
            .round_i (ascon_pkg::round_idx_t'(round_base + k)),
            .state_o (chain[k+1])
        );
    end

    // Round counter and busy flag
    always_ff @(posedge clk) begin
        if (rst_i) begin
            running   <= 1'b0;
            round_cnt <= '0;
        end else if (perm.start) begin
            running   <= 1'b1;
            round_cnt <= ascon_pkg::round_idx_t'(ROUNDS_PER_CYCLE);
        end else if (last_step) begin
            running   <= 1'b0;
            round_cnt <= '0;
        end else if (running) begin
            round_cnt <= round_cnt + ascon_pkg::round_idx_t'(ROUNDS_PER_CYCLE);
        end
    end

    // State register, rounds take priority over a plain load
    always_ff @(posedge clk) begin
        if (perm.start || running) begin
            state_q <= chain[ROUNDS_PER_CYCLE];
        end else if (perm.load) begin
            state_q <= chain[0];
        end
    end

    assign perm.state = state_q.flat;
    assign perm.ready = ~running;

endmodule

//--- hdl/ascon_round.sv
// ----------------------------------------------------------
// One Ascon round, purely combinational
// Constant addition, 5-bit S-box layer and linear diffusion
// ----------------------------------------------------------
`timescale 1ns/10ps

module ascon_round (
    input  ascon_pkg::state_u     state_i,
    input  ascon_pkg::round_idx_t round_i,
    output ascon_pkg::state_u     state_o
);

    // Working copies of the five lanes
    ascon_pkg::lane_t a0, a1, a2, a3, a4;
    ascon_pkg::lane_t t0, t1, t2, t3, t4;

    // Right rotation of one lane
    function automatic ascon_pkg::lane_t ror(input ascon_pkg::lane_t v, input int n);
        return (v >> n) | (v << (64 - n));
    endfunction

    always_comb begin
        // ------------------------------------------------------
        // Constant addition on x2
        // ------------------------------------------------------
        a0 = state_i.x[0];
        a1 = state_i.x[1];
        a2 = state_i.x[2] ^ {56'd0, ascon_pkg::ROUND_CONST[round_i]};
        a3 = state_i.x[3];
        a4 = state_i.x[4];

        // ------------------------------------------------------
        // Substitution layer, bit-sliced across lanes
        // ------------------------------------------------------
        a0 = a0 ^ a4;
        a4 = a4 ^ a3;
        a2 = a2 ^ a1;
        // Chi-like nonlinear step
        t0 = ~a0 & a1;
        t1 = ~a1 & a2;
        t2 = ~a2 & a3;
        t3 = ~a3 & a4;
        t4 = ~a4 & a0;
        a0 = a0 ^ t1;
        a1 = a1 ^ t2;
        a2 = a2 ^ t3;
        a3 = a3 ^ t4;
        a4 = a4 ^ t0;
        // Output mixing of the S-box
        a1 = a1 ^ a0;
        a0 = a0 ^ a4;
        a3 = a3 ^ a2;
        a2 = ~a2;

        // ------------------------------------------------------
        // Linear diffusion, own rotation pair per lane
        // ------------------------------------------------------
        state_o.x[0] = a0 ^ ror(a0, 19) ^ ror(a0, 28);
        state_o.x[1] = a1 ^ ror(a1, 61) ^ ror(a1, 39);
        state_o.x[2] = a2 ^ ror(a2, 1) ^ ror(a2, 6);
        state_o.x[3] = a3 ^ ror(a3, 10) ^ ror(a3, 17);
        state_o.x[4] = a4 ^ ror(a4, 7) ^ ror(a4, 41);
    end

endmodule

//--- hdl/perm_if.sv
// ----------------------------------------------------------
// Control and state channel between controller and permutation
// ----------------------------------------------------------
`timescale 1ns/10ps

interface perm_if;

    // One-cycle write of load_state into the state register
    logic load;
    ascon_pkg::state_t load_state;

    // One-cycle pulse that kicks off p12
    logic start;

    // Register contents, always visible
    ascon_pkg::state_t state;

    // Low while rounds are in flight
    logic ready;

    // Controller side
    modport ctrl (
        output load,
        output load_state,
        output start,
        input  state,
        input  ready
    );

    // Core side
    modport perm (
        input  load,
        input  load_state,
        input  start,
        output state,
        output ready
    );

endinterface

//--- hdl/block_if.sv
// ----------------------------------------------------------
// Padded block channel from the padder to the hash controller
// ----------------------------------------------------------
`timescale 1ns/10ps

interface block_if;

    // Padded rate block, byte 0 in the low bits
    hash_pkg::block_t blk_data;

    // Last padded block of the message
    logic blk_final;

    // Block on blk_data is held and waiting
    logic blk_valid;

    // Controller can absorb this cycle
    logic blk_ready;

    // Framer side
    modport padder (
        output blk_data,
        output blk_final,
        output blk_valid,
        input  blk_ready
    );

    // Sponge side
    modport ctrl (
        input  blk_data,
        input  blk_final,
        input  blk_valid,
        output blk_ready
    );

endinterface

//--- hdl/hash_pkg.sv
// ----------------------------------------------------------
// Ascon-Hash256 protocol definitions
// Rate, byte enables, initial value and digest size
// ----------------------------------------------------------
package hash_pkg;

    // Rate of the sponge in bits
    localparam int BLOCK_BITS = 64;

    // One enable per byte of a block
    localparam int KEEP_BITS = BLOCK_BITS / 8;

    // One rate-sized block, byte 0 in bits 7:0
    typedef logic [BLOCK_BITS-1:0] block_t;

    // Byte enables for one beat
    typedef logic [KEEP_BITS-1:0] keep_t;

    // Initial value for lane x0, all other lanes start at zero
    localparam logic [63:0] HASH_IV = 64'h0000080100cc0002;

    // 256-bit digest leaves as four 64-bit beats
    localparam int DIGEST_WORDS = 4;

    // Counts the squeeze beats
    typedef logic [1:0] beat_cnt_t;

endpackage

//--- hdl/ascon_pkg.sv
// ----------------------------------------------------------
// Ascon permutation definitions
// State layout, lane views and the p12 round constants
// ----------------------------------------------------------
package ascon_pkg;

    // One 64-bit lane of the sponge state
    typedef logic [63:0] lane_t;

    // Whole 320-bit state as one flat vector
    typedef logic [319:0] state_t;

    // Same state seen two ways
    // Lane x0 sits in bits 63:0, lane x4 in bits 319:256
    typedef union packed {
        state_t        flat;
        lane_t [4:0]   x;
    } state_u;

    // Rounds in p12
    localparam int ROUNDS = 12;

    // Round index, wide enough for 0 to 11
    typedef logic [3:0] round_idx_t;

    // Constants added to x2, one per round of p12
    localparam logic [7:0] ROUND_CONST [ROUNDS] = '{
        8'hf0, 8'he1, 8'hd2, 8'hc3,
        8'hb4, 8'ha5, 8'h96, 8'h87,
        8'h78, 8'h69, 8'h5a, 8'h4b
    };

endpackage
